/* Makefile */
TOP := taint_track_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): taint_track_top.f $(wildcard logic/*.sv logic/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f taint_track_top.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f taint_track_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* logic/taint_alu.sv */
`timescale 1ns/1ps

module taint_alu (
    input  logic                      pos_clk,
    input  logic                      pos_arst,
    input  logic                      op_valid,
    input  taint_track_pkg::taint_op_e op_code,
    input  taint_track_pkg::data_t    op_a,
    input  taint_track_pkg::data_t    op_a_taint,
    input  taint_track_pkg::data_t    op_b,
    input  taint_track_pkg::data_t    op_b_taint,
    input  taint_track_pkg::addr_t    wr_addr,
    input  taint_track_pkg::addr_t    wr_addr_taint,
    taint_wr_if.src                   wr
);

    // operands with tainted bits forced low and forced high
    taint_track_pkg::data_t a_lo;
    taint_track_pkg::data_t a_hi;
    taint_track_pkg::data_t b_lo;
    taint_track_pkg::data_t b_hi;
    taint_track_pkg::data_t res_taint;

    assign a_lo = op_a & ~op_a_taint;
    assign a_hi = op_a | op_a_taint;
    assign b_lo = op_b & ~op_b_taint;
    assign b_hi = op_b | op_b_taint;

    always_comb begin
        case (op_code)
            taint_track_pkg::op_and: begin
                // a one on the clean side lets the other taint through
                res_taint = (op_a_taint & op_b) | (op_b_taint & op_a) | (op_a_taint & op_b_taint);
            end
            taint_track_pkg::op_or: begin
                res_taint = (op_a_taint & ~op_b) | (op_b_taint & ~op_a) |
                            (op_a_taint & op_b_taint);
            end
            taint_track_pkg::op_add: begin
                // bits that move between the two extreme sums are tainted
                res_taint = ((a_lo + b_lo) ^ (a_hi + b_hi)) | op_a_taint | op_b_taint;
            end
            taint_track_pkg::op_sub: begin
                res_taint = ((a_lo - b_lo) ^ (a_hi - b_hi)) | op_a_taint | op_b_taint;
            end
            taint_track_pkg::op_shl: begin
                res_taint = (|op_b_taint) ? '1 : op_a_taint << op_b;
            end
            taint_track_pkg::op_shr: begin
                res_taint = (|op_b_taint) ? '1 : op_a_taint >> op_b;
            end
            default: begin
                // conservative rule, any input taint spreads everywhere
                res_taint = (|{op_a_taint, op_b_taint}) ? '1 : '0;
            end
        endcase
    end

    // one result per strobe, presented to the memory the next cycle
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            wr.valid      <= 1'b0;
            wr.addr       <= '0;
            wr.addr_taint <= 1'b0;
            wr.data_taint <= '0;
        end else begin
            wr.valid <= op_valid;
            if (op_valid) begin
                wr.addr       <= wr_addr;
                wr.addr_taint <= |wr_addr_taint;
                wr.data_taint <= res_taint;
            end
        end
    end

    // clean and or add operands never create taint in the stored result
    assert property (@(posedge pos_clk) disable iff (pos_arst)
        op_valid && (op_code == taint_track_pkg::op_and || op_code == taint_track_pkg::op_add)
        && op_a_taint == '0 && op_b_taint == '0
        |=> wr.valid && wr.data_taint == '0);

endmodule

/* logic/taint_live_count.sv */
`timescale 1ns/1ps

`include "taint_track_cfg.svh"

module taint_live_count (
    input  logic                    pos_clk,
    input  logic                    pos_arst,
    input  logic [`TT_DEPTH-1:0]    entry_tainted,
    input  taint_track_pkg::addr_t  live_head,
    input  taint_track_pkg::addr_t  live_tail,
    output taint_track_pkg::count_t taint_sum
);

    logic [`TT_DEPTH-1:0]    live;
    taint_track_pkg::count_t count_next;

    // queue window between head and tail, wrapping when head is above tail
    always_comb begin
        for (int i = 0; i < `TT_DEPTH; i++) begin
            if (live_head < live_tail) begin
                live[i] = (live_head <= taint_track_pkg::addr_t'(i)) &&
                          (taint_track_pkg::addr_t'(i) <= live_tail);
            end else if (live_head > live_tail) begin
                live[i] = (live_head <= taint_track_pkg::addr_t'(i)) ||
                          (taint_track_pkg::addr_t'(i) <= live_tail);
            end else begin
                // empty queue
                live[i] = 1'b0;
            end
        end
    end

    always_comb begin
        count_next = '0;
        for (int i = 0; i < `TT_DEPTH; i++) begin
            if (live[i] && entry_tainted[i]) begin
                count_next = count_next + 1'b1;
            end
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            taint_sum <= '0;
        end else begin
            taint_sum <= count_next;
        end
    end

    // never more tainted entries than the memory holds
    assert property (@(posedge pos_clk) disable iff (pos_arst)
        taint_sum <= taint_track_pkg::count_t'(`TT_DEPTH));

endmodule

/* logic/taint_shadow_mem.sv */
`timescale 1ns/1ps

`include "taint_track_cfg.svh"

module taint_shadow_mem (
    input  logic                   pos_clk,
    input  logic                   pos_arst,
    taint_wr_if.dst                wr,
    input  logic                   rd_en,
    input  taint_track_pkg::addr_t rd_addr,
    input  taint_track_pkg::addr_t rd_addr_taint,
    output logic                   rd_valid,
    output taint_track_pkg::data_t rd_data_taint,
    output logic [`TT_DEPTH-1:0]   entry_tainted
);

    taint_track_pkg::data_t mem [`TT_DEPTH];

    // a tainted address may have hit any entry, so the whole word is tainted
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < `TT_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.valid) begin
            mem[wr.addr] <= wr.data_taint | (wr.addr_taint ? '1 : '0);
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // old entry is returned on a same-cycle read and write
    always_ff @(posedge pos_clk) begin
        if (rd_en) begin
            rd_data_taint <= mem[rd_addr] | ((|rd_addr_taint) ? '1 : '0);
        end
    end

    // per-entry flag for the liveness counter
    always_comb begin
        for (int i = 0; i < `TT_DEPTH; i++) begin
            entry_tainted[i] = |mem[i];
        end
    end

    // two valid reads in a row need two read requests behind them
    assert property (@(posedge pos_clk) disable iff (pos_arst)
        rd_valid && $past(rd_valid) |-> $past(rd_en, 1) && $past(rd_en, 2));

endmodule

/* logic/taint_track_cfg.svh */
`ifndef TAINT_TRACK_CFG_SVH
`define TAINT_TRACK_CFG_SVH

// operand and taint word width
`define TT_DATA_W 16

// shadow memory geometry, depth is two to the power of the address width
`define TT_ADDR_W 3
`define TT_DEPTH  8

`endif

/* logic/taint_track_pkg.sv */
`include "taint_track_cfg.svh"

package taint_track_pkg;

    // operation whose result taint is propagated
    typedef enum logic [2:0] {
        op_and   = 3'd0,
        op_or    = 3'd1,
        op_add   = 3'd2,
        op_sub   = 3'd3,
        op_shl   = 3'd4,
        op_shr   = 3'd5,
        op_other = 3'd6
    } taint_op_e;

    // value or taint word
    typedef logic [`TT_DATA_W-1:0] data_t;

    // shadow memory address
    typedef logic [`TT_ADDR_W-1:0] addr_t;

    // entry count, one bit wider so a full memory fits
    typedef logic [`TT_ADDR_W:0] count_t;

endpackage

/* logic/taint_track_top.sv */
`timescale 1ns/1ps

`include "taint_track_cfg.svh"

module taint_track_top (
    input  logic                       pos_clk,
    input  logic                       pos_arst,
    input  logic                       op_valid,
    input  taint_track_pkg::taint_op_e op_code,
    input  taint_track_pkg::data_t     op_a,
    input  taint_track_pkg::data_t     op_a_taint,
    input  taint_track_pkg::data_t     op_b,
    input  taint_track_pkg::data_t     op_b_taint,
    input  taint_track_pkg::addr_t     wr_addr,
    input  taint_track_pkg::addr_t     wr_addr_taint,
    input  logic                       rd_en,
    input  taint_track_pkg::addr_t     rd_addr,
    input  taint_track_pkg::addr_t     rd_addr_taint,
    input  taint_track_pkg::addr_t     live_head,
    input  taint_track_pkg::addr_t     live_tail,
    output logic                       rd_valid,
    output taint_track_pkg::data_t     rd_data_taint,
    output taint_track_pkg::count_t    taint_sum
);

    // result taint writes from the propagation unit
    taint_wr_if wr_bus ();

    logic [`TT_DEPTH-1:0] entry_tainted;

    taint_alu u_taint_alu (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .op_valid      (op_valid),
        .op_code       (op_code),
        .op_a          (op_a),
        .op_a_taint    (op_a_taint),
        .op_b          (op_b),
        .op_b_taint    (op_b_taint),
        .wr_addr       (wr_addr),
        .wr_addr_taint (wr_addr_taint),
        .wr            (wr_bus.src)
    );

    taint_shadow_mem u_taint_shadow_mem (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .wr            (wr_bus.dst),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_addr_taint (rd_addr_taint),
        .rd_valid      (rd_valid),
        .rd_data_taint (rd_data_taint),
        .entry_tainted (entry_tainted)
    );

    taint_live_count u_taint_live_count (
        .pos_clk       (pos_clk),
        .pos_arst      (pos_arst),
        .entry_tainted (entry_tainted),
        .live_head     (live_head),
        .live_tail     (live_tail),
        .taint_sum     (taint_sum)
    );

endmodule

/* logic/taint_wr_if.sv */
`timescale 1ns/1ps

interface taint_wr_if;

    // one-cycle write strobe
    logic                   valid;
    taint_track_pkg::addr_t addr;
    // set when any write address bit carries taint
    logic                   addr_taint;
    taint_track_pkg::data_t data_taint;

    modport src (
        output valid,
        output addr,
        output addr_taint,
        output data_taint
    );

    modport dst (
        input valid,
        input addr,
        input addr_taint,
        input data_taint
    );

endinterface

/* taint_track_top.f */
+incdir+logic
logic/taint_track_pkg.sv
logic/taint_wr_if.sv
logic/taint_alu.sv
logic/taint_shadow_mem.sv
logic/taint_live_count.sv
logic/taint_track_top.sv
testbench/taint_track_tb.sv

/* testbench/taint_track_tb.sv */
`timescale 1ns/1ps

`include "taint_track_cfg.svh"

module taint_track_tb;

    typedef taint_track_pkg::data_t data_t;
    typedef taint_track_pkg::addr_t addr_t;

    // roughly ten times the length of all directed tests
    localparam int TIMEOUT_CYCLES = 2000;
    localparam data_t ALL_ONES = '1;

    logic                       pos_clk;
    logic                       pos_arst;
    logic                       op_valid;
    taint_track_pkg::taint_op_e op_code;
    data_t                      op_a;
    data_t                      op_a_taint;
    data_t                      op_b;
    data_t                      op_b_taint;
    addr_t                      wr_addr;
    addr_t                      wr_addr_taint;
    logic                       rd_en;
    addr_t                      rd_addr;
    addr_t                      rd_addr_taint;
    addr_t                      live_head;
    addr_t                      live_tail;
    logic                       rd_valid;
    data_t                      rd_data_taint;
    taint_track_pkg::count_t    taint_sum;

    // expected contents of the shadow memory
    data_t       model_mem [`TT_DEPTH];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    taint_track_top u_taint_track_top (.*);

    initial begin
        pos_clk = 1'b0;
        forever #5 pos_clk = ~pos_clk;
    end

    always @(posedge pos_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_equal(input string name, input data_t expected, input data_t actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Fail %s: expected %h, actual %h",
                                        name, expected, actual));
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step;
        @(posedge pos_clk);
        #1;
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic data_t random_bits(input int width);
        data_t v;
        v = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[`TT_DATA_W-2:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic data_t model_taint(input taint_track_pkg::taint_op_e op,
                                          input data_t a, input data_t at,
                                          input data_t b, input data_t bt);
        data_t t;
        data_t lo;
        data_t hi;
        logic  ctl;
        int    src;
        t = '0;
        case (op)
            taint_track_pkg::op_and, taint_track_pkg::op_or: begin
                // the clean side passes taint only where its bit does not fix the result
                ctl = (op == taint_track_pkg::op_and);
                for (int i = 0; i < `TT_DATA_W; i++) begin
                    t[i] = (at[i] && bt[i]) || (at[i] && b[i] == ctl) || (bt[i] && a[i] == ctl);
                end
            end
            taint_track_pkg::op_add, taint_track_pkg::op_sub: begin
                // tainted bits all cleared, then all set
                lo = (op == taint_track_pkg::op_add) ? (a & ~at) + (b & ~bt) :
                                                       (a & ~at) - (b & ~bt);
                hi = (op == taint_track_pkg::op_add) ? (a | at) + (b | bt) :
                                                       (a | at) - (b | bt);
                for (int i = 0; i < `TT_DATA_W; i++) begin
                    t[i] = (lo[i] != hi[i]) || at[i] || bt[i];
                end
            end
            taint_track_pkg::op_shl, taint_track_pkg::op_shr: begin
                for (int i = 0; i < `TT_DATA_W; i++) begin
                    // source bit of operand A that lands on bit i
                    src = (op == taint_track_pkg::op_shl) ? i - int'(b) : i + int'(b);
                    if (bt != '0) begin
                        t[i] = 1'b1;
                    end else if (src >= 0 && src < `TT_DATA_W) begin
                        t[i] = at[src];
                    end
                end
            end
            default: t = ((at | bt) != '0) ? ALL_ONES : '0;
        endcase
        return t;
    endfunction

    // walk the queue from head to tail, wrapping at the last entry
    function automatic data_t count_live(input addr_t head, input addr_t tail);
        int n;
        int pos;
        n = 0;
        if (head != tail) begin
            for (int k = 0; k < `TT_DEPTH; k++) begin
                pos = (int'(head) + k) % `TT_DEPTH;
                if (model_mem[pos] != '0) n++;
                if (addr_t'(pos) == tail) break;
            end
        end
        return data_t'(n);
    endfunction

    task automatic do_write(input taint_track_pkg::taint_op_e op, input data_t a, input data_t at,
                            input data_t b, input data_t bt, input addr_t addr,
                            input addr_t addr_taint);
        op_valid      = 1'b1;
        op_code       = op;
        op_a          = a;
        op_a_taint    = at;
        op_b          = b;
        op_b_taint    = bt;
        wr_addr       = addr;
        wr_addr_taint = addr_taint;
        // a tainted address widens the stored word to all ones
        model_mem[addr] = (addr_taint != '0) ? ALL_ONES : model_taint(op, a, at, b, bt);
        step();
        op_valid = 1'b0;
    endtask

    task automatic do_read(input addr_t addr, input addr_t addr_taint, output data_t data);
        rd_en         = 1'b1;
        rd_addr       = addr;
        rd_addr_taint = addr_taint;
        step();
        rd_en = 1'b0;
        // response is due one cycle after the request
        if (!rd_valid) begin
            stop_with_failure("read response did not arrive one cycle after a read request");
        end else begin
            data = rd_data_taint;
        end
    endtask

    task automatic write_and_check(input string name, input taint_track_pkg::taint_op_e op,
                                   input data_t a, input data_t at, input data_t b,
                                   input data_t bt, input addr_t addr);
        data_t got;
        do_write(op, a, at, b, bt, addr, '0);
        // memory takes the result one edge after the unit registers it
        step();
        // the previous read pulse is over by now
        check_equal(name, '0, data_t'(rd_valid));
        do_read(addr, '0, got);
        check_equal(name, model_mem[addr], got);
    endtask

    task automatic test_reset_state;
        data_t got;
        check_equal("test_reset_state", '0, data_t'(rd_valid));
        live_head = '0;
        live_tail = addr_t'(`TT_DEPTH - 1);
        step();
        check_equal("test_reset_state", '0, data_t'(taint_sum));
        for (int i = 0; i < `TT_DEPTH; i++) begin
            do_read(addr_t'(i), '0, got);
            check_equal("test_reset_state", '0, got);
        end
    endtask

    task automatic test_logic_ops;
        taint_track_pkg::taint_op_e ops [3] = '{taint_track_pkg::op_and, taint_track_pkg::op_or,
                                                taint_track_pkg::op_other};
        data_t a;
        data_t at;
        data_t b;
        data_t bt;
        for (int j = 0; j < 3; j++) begin
            for (int k = 0; k < 4; k++) begin
                a  = random_bits(16);
                at = random_bits(16) & random_bits(16);
                b  = random_bits(16);
                bt = random_bits(16) & random_bits(16);
                write_and_check("test_logic_ops", ops[j], a, at, b, bt, addr_t'(j * 4 + k));
            end
        end
    endtask

    task automatic test_arith_shift;
        taint_track_pkg::taint_op_e ops [4] = '{taint_track_pkg::op_add, taint_track_pkg::op_sub,
                                                taint_track_pkg::op_shl, taint_track_pkg::op_shr};
        data_t a;
        data_t at;
        data_t b;
        data_t bt;
        for (int j = 0; j < 4; j++) begin
            for (int k = 0; k < 3; k++) begin
                a  = random_bits(16);
                at = random_bits(16) & random_bits(16);
                // shift amounts stay below the word width
                b  = (j >= 2) ? random_bits(4) : random_bits(16);
                bt = (j >= 2) ? '0 : random_bits(16) & random_bits(16);
                write_and_check("test_arith_shift", ops[j], a, at, b, bt, addr_t'(k));
            end
            // clean operands
            write_and_check("test_arith_shift", ops[j], random_bits(16), '0, random_bits(4), '0,
                            3'd3);
            // a tainted shift amount or operand B
            write_and_check("test_arith_shift", ops[j], random_bits(16), '0, random_bits(4),
                            16'h0002, 3'd4);
        end
    endtask

    task automatic test_addr_taint;
        data_t got;
        do_write(taint_track_pkg::op_and, 16'h1234, '0, 16'hff00, '0, 3'd5, 3'b010);
        step();
        do_read(3'd5, '0, got);
        check_equal("test_addr_taint", ALL_ONES, got);
        do_write(taint_track_pkg::op_or, 16'h00f0, '0, 16'h0f00, '0, 3'd6, '0);
        step();
        do_read(3'd6, '0, got);
        check_equal("test_addr_taint", '0, got);
        // clean entry seen through a tainted read address
        do_read(3'd6, 3'b001, got);
        check_equal("test_addr_taint", ALL_ONES, got);
    endtask

    task automatic check_window(input addr_t head, input addr_t tail);
        live_head = head;
        live_tail = tail;
        step();
        check_equal("test_liveness", count_live(head, tail), data_t'(taint_sum));
    endtask

    task automatic test_liveness;
        for (int i = 0; i < `TT_DEPTH; i++) begin
            if (i == 1 || i == 2 || i == 5 || i == 7) begin
                write_and_check("test_liveness", taint_track_pkg::op_other, 16'h0042, 16'h0100,
                                16'h0007, '0, addr_t'(i));
            end else begin
                write_and_check("test_liveness", taint_track_pkg::op_and, 16'h0042, '0,
                                16'h0007, '0, addr_t'(i));
            end
        end
        check_window(3'd1, 3'd5);
        check_window(3'd6, 3'd1);
        check_window(3'd3, 3'd3);
        check_window(3'd0, 3'd7);
    endtask

    task automatic test_back_to_back;
        logic [2:0] sel;
        data_t      b;
        data_t      got;
        for (int i = 0; i < `TT_DEPTH; i++) begin
            sel = 3'(random_bits(3));
            if (sel == 3'd7) sel = 3'd6;
            b = random_bits(16);
            if (sel == 3'd4 || sel == 3'd5) b = b & 16'h000f;
            do_write(taint_track_pkg::taint_op_e'(sel), random_bits(16),
                     random_bits(16) & random_bits(16), b, random_bits(16) & random_bits(16),
                     addr_t'(i), '0);
        end
        step();
        for (int i = 0; i < `TT_DEPTH; i++) begin
            do_read(addr_t'(i), '0, got);
            check_equal("test_back_to_back", model_mem[i], got);
        end
    endtask

    initial begin
        lfsr_state    = 32'h9dae_7295;
        pos_arst      = 1'b1;
        op_valid      = 1'b0;
        op_code       = taint_track_pkg::op_and;
        op_a          = '0;
        op_a_taint    = '0;
        op_b          = '0;
        op_b_taint    = '0;
        wr_addr       = '0;
        wr_addr_taint = '0;
        rd_en         = 1'b0;
        rd_addr       = '0;
        rd_addr_taint = '0;
        live_head     = '0;
        live_tail     = '0;
        for (int i = 0; i < `TT_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (16) @(posedge pos_clk);
        #1;
        pos_arst = 1'b0;
        test_reset_state();
        test_logic_ops();
        test_arith_shift();
        test_addr_taint();
        test_liveness();
        test_back_to_back();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
